/* hdl/dec_consts.svh */
// widths and sizes for the decode operand path
// datapath, register file, value predictor and trace cause

`ifndef DEC_CONSTS_SVH
`define DEC_CONSTS_SVH

`define DEC_XLEN     32   // data word
`define DEC_GPR_AW   5    // register number
`define DEC_PC_W     31   // pc bits 31:1

`define VP_ENTRIES   128  // predictor table depth
`define VP_IDX_W     7    // pc bits 7:1
`define VP_TAG_W     8    // pc bits 15:8
`define VP_CONF_W    2
`define VP_CONF_MAX  3    // confidence needed to use a prediction

`define DEC_CAUSE_W  5    // trap cause

`endif

/* hdl/dec_pkg.sv */
// datapath and trace types
// shared by the register file, the trace builder and the top

`include "dec_consts.svh"

package dec_pkg;

   localparam int TRACE_LANES = 3;  // slot 0, slot 1, interrupt

   typedef logic [`DEC_XLEN-1:0]   xlen_t;
   typedef logic [`DEC_GPR_AW-1:0] gpr_addr_t;
   typedef logic [`DEC_PC_W-1:0]   pc_t;        // half-word pc

   // trace port, lane 0 in the low bits
   typedef logic [TRACE_LANES*`DEC_XLEN-1:0] trace_insn_t;
   typedef logic [TRACE_LANES*`DEC_XLEN-1:0] trace_addr_t;
   typedef logic [TRACE_LANES-1:0]           trace_lane_t;

endpackage

/* hdl/vp_pkg.sv */
// value predictor types
// table index, tag and confidence, feedback update action
// pc to index and tag split used by lookup and training

`include "dec_consts.svh"

package vp_pkg;

   typedef logic [`VP_IDX_W-1:0]  vp_idx_t;
   typedef logic [`VP_TAG_W-1:0]  vp_tag_t;
   typedef logic [`VP_CONF_W-1:0] vp_conf_t;

   typedef enum logic [1:0] {
      VP_UPD_NONE    = 2'd0,  // no feedback this slot
      VP_UPD_TRAIN   = 2'd1,  // confidence up
      VP_UPD_REPLACE = 2'd2   // new value and tag, confidence back to 0
   } vp_update_e;

   // index from pc bits 7:1
   function automatic vp_idx_t vp_index(input logic [`DEC_PC_W-1:0] pc);
      return pc[`VP_IDX_W-1:0];
   endfunction

   // tag from pc bits 15:8
   function automatic vp_tag_t vp_tag(input logic [`DEC_PC_W-1:0] pc);
      return pc[`VP_IDX_W +: `VP_TAG_W];
   endfunction

endpackage

/* hdl/dec_vp_lookup.sv */
// value predictor lookup side
// align pc split, tag compare, D and E1 result registers

`timescale 1ns/1ps
`include "dec_consts.svh"

module dec_vp_lookup
   import dec_pkg::*;
   import vp_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n_i,
   input  pc_t      pc0_aln_i,     // align stage pcs
   input  pc_t      pc1_aln_i,
   input  logic     rd_valid0_i,   // table entry, same cycle
   input  logic     rd_valid1_i,
   input  vp_tag_t  rd_tag0_i,
   input  vp_tag_t  rd_tag1_i,
   input  vp_conf_t rd_conf0_i,
   input  vp_conf_t rd_conf1_i,
   input  xlen_t    rd_value0_i,
   input  xlen_t    rd_value1_i,
   output vp_idx_t  rd_idx0_o,
   output vp_idx_t  rd_idx1_o,
   output vp_conf_t conf0_d_o,     // 0 on miss
   output vp_conf_t conf1_d_o,
   output logic     use0_e1_o,
   output logic     use1_e1_o,
   output xlen_t    value0_e1_o,
   output xlen_t    value1_e1_o
);

   logic     hit_a  [2];  // entry valid and tag match
   vp_conf_t conf_d [2];
   logic     use_d  [2];
   xlen_t    val_d  [2];
   logic     use_e1 [2];
   xlen_t    val_e1 [2];

   assign rd_idx0_o = vp_index(pc0_aln_i);
   assign rd_idx1_o = vp_index(pc1_aln_i);

   assign hit_a[0] = rd_valid0_i && (rd_tag0_i == vp_tag(pc0_aln_i));
   assign hit_a[1] = rd_valid1_i && (rd_tag1_i == vp_tag(pc1_aln_i));

   //**************************************************************************
   // align -> D -> E1
   //**************************************************************************
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         conf_d <= '{default: '0};
         use_d  <= '{default: 1'b0};
         use_e1 <= '{default: 1'b0};
      end else begin
         conf_d[0] <= hit_a[0] ? rd_conf0_i : '0;
         conf_d[1] <= hit_a[1] ? rd_conf1_i : '0;
         use_d[0]  <= hit_a[0] && (rd_conf0_i == vp_conf_t'(`VP_CONF_MAX));  // fully confident
         use_d[1]  <= hit_a[1] && (rd_conf1_i == vp_conf_t'(`VP_CONF_MAX));
         use_e1    <= use_d;
      end
   end

   always_ff @(posedge clk) begin
      val_d[0] <= rd_value0_i;
      val_d[1] <= rd_value1_i;
      val_e1   <= val_d;  // value follows use flag
   end

   assign conf0_d_o   = conf_d[0];
   assign conf1_d_o   = conf_d[1];
   assign use0_e1_o   = use_e1[0];
   assign use1_e1_o   = use_e1[1];
   assign value0_e1_o = val_e1[0];
   assign value1_e1_o = val_e1[1];

endmodule

/* hdl/dec_vp_table.sv */
// value predictor storage
// valid, tag, confidence and value per entry
// writeback feedback training, slot 1 wins on a shared index

`timescale 1ns/1ps
`include "dec_consts.svh"

module dec_vp_table
   import dec_pkg::*;
   import vp_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n_i,
   input  vp_idx_t  rd_idx0_i,
   input  vp_idx_t  rd_idx1_i,
   input  logic     fb_valid0_i,   // writeback feedback
   input  logic     fb_valid1_i,
   input  logic     fb_misp0_i,
   input  logic     fb_misp1_i,
   input  pc_t      fb_pc0_i,
   input  pc_t      fb_pc1_i,
   input  xlen_t    fb_actual0_i,  // actual result
   input  xlen_t    fb_actual1_i,
   output logic     rd_valid0_o,
   output logic     rd_valid1_o,
   output vp_tag_t  rd_tag0_o,
   output vp_tag_t  rd_tag1_o,
   output vp_conf_t rd_conf0_o,
   output vp_conf_t rd_conf1_o,
   output xlen_t    rd_value0_o,
   output xlen_t    rd_value1_o
);

   logic [`VP_ENTRIES-1:0] valid_q;
   vp_tag_t                tag_q   [`VP_ENTRIES];
   vp_conf_t               conf_q  [`VP_ENTRIES];
   xlen_t                  value_q [`VP_ENTRIES];

   logic       fb_valid  [2];
   logic       fb_misp   [2];
   pc_t        fb_pc     [2];
   xlen_t      fb_actual [2];
   vp_idx_t    fb_idx    [2];
   vp_tag_t    fb_tag    [2];
   vp_update_e upd       [2];
   logic       apply     [2];  // slot writes this cycle

   assign fb_valid  = '{fb_valid0_i, fb_valid1_i};
   assign fb_misp   = '{fb_misp0_i, fb_misp1_i};
   assign fb_pc     = '{fb_pc0_i, fb_pc1_i};
   assign fb_actual = '{fb_actual0_i, fb_actual1_i};

   //**************************************************************************
   // feedback action per slot
   //**************************************************************************
   always_comb begin
      for (int s = 0; s < 2; s++) begin
         fb_idx[s] = vp_index(fb_pc[s]);
         fb_tag[s] = vp_tag(fb_pc[s]);
         if (!fb_valid[s]) begin
            upd[s] = VP_UPD_NONE;
         end else if (fb_misp[s] || !valid_q[fb_idx[s]] ||
                      (tag_q[fb_idx[s]] != fb_tag[s])) begin
            upd[s] = VP_UPD_REPLACE;  // wrong value or tag miss
         end else begin
            upd[s] = VP_UPD_TRAIN;
         end
      end
      apply[1] = (upd[1] != VP_UPD_NONE);
      apply[0] = (upd[0] != VP_UPD_NONE) && !(apply[1] && (fb_idx[1] == fb_idx[0]));
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         valid_q <= '0;
      end else begin
         for (int s = 0; s < 2; s++) begin
            if (apply[s] && (upd[s] == VP_UPD_REPLACE)) valid_q[fb_idx[s]] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int s = 0; s < 2; s++) begin
         if (apply[s]) begin
            case (upd[s])
               VP_UPD_REPLACE: begin
                  tag_q[fb_idx[s]]   <= fb_tag[s];
                  value_q[fb_idx[s]] <= fb_actual[s];
                  conf_q[fb_idx[s]]  <= '0;
               end
               VP_UPD_TRAIN: begin  // saturating
                  if (conf_q[fb_idx[s]] != vp_conf_t'(`VP_CONF_MAX))
                     conf_q[fb_idx[s]] <= conf_q[fb_idx[s]] + vp_conf_t'(1);
               end
               default: ;
            endcase
         end
      end
   end

   // reads see contents before this edge's update
   assign rd_valid0_o = valid_q[rd_idx0_i];
   assign rd_valid1_o = valid_q[rd_idx1_i];
   assign rd_tag0_o   = tag_q[rd_idx0_i];
   assign rd_tag1_o   = tag_q[rd_idx1_i];
   assign rd_conf0_o  = conf_q[rd_idx0_i];
   assign rd_conf1_o  = conf_q[rd_idx1_i];
   assign rd_value0_o = value_q[rd_idx0_i];
   assign rd_value1_o = value_q[rd_idx1_i];

endmodule

/* hdl/dec_gpr_file.sv */
// architectural register file, x1 to x31
// four combinational read ports, three write ports

`timescale 1ns/1ps
`include "dec_consts.svh"

module dec_gpr_file
   import dec_pkg::*;
(
   input  logic      clk,
   input  gpr_addr_t rs0_i,     // slot 0 rs1
   input  gpr_addr_t rs1_i,     // slot 0 rs2
   input  gpr_addr_t rs2_i,     // slot 1 rs1
   input  gpr_addr_t rs3_i,     // slot 1 rs2
   input  logic      wen0_i,    // slot 0 writeback
   input  logic      wen1_i,    // slot 1 writeback
   input  logic      wen2_i,    // non-blocking load return
   input  gpr_addr_t waddr0_i,
   input  gpr_addr_t waddr1_i,
   input  gpr_addr_t waddr2_i,
   input  xlen_t     wd0_i,
   input  xlen_t     wd1_i,
   input  xlen_t     wd2_i,
   output xlen_t     rd0_o,
   output xlen_t     rd1_o,
   output xlen_t     rd2_o,
   output xlen_t     rd3_o
);

   xlen_t regs_q [1:(2**`DEC_GPR_AW)-1];  // no x0 storage

   //**************************************************************************
   // writes, last one wins: load < slot 0 < slot 1
   //**************************************************************************
   always_ff @(posedge clk) begin
      if (wen2_i && (waddr2_i != '0)) regs_q[waddr2_i] <= wd2_i;
      if (wen0_i && (waddr0_i != '0)) regs_q[waddr0_i] <= wd0_i;
      if (wen1_i && (waddr1_i != '0)) regs_q[waddr1_i] <= wd1_i;
   end

   // x0 reads zero
   assign rd0_o = (rs0_i == '0) ? '0 : regs_q[rs0_i];
   assign rd1_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
   assign rd2_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];
   assign rd3_o = (rs3_i == '0) ? '0 : regs_q[rs3_i];

endmodule

/* hdl/dec_trace_pack.sv */
// trace packet builder
// writeback retirement info registered to WB1 and packed into lanes

`timescale 1ns/1ps
`include "dec_consts.svh"

module dec_trace_pack
   import dec_pkg::*;
(
   input  logic                   clk,
   input  logic                   arst_n_i,
   input  logic                   i0_valid_wb_i,   // retired at wb
   input  logic                   i1_valid_wb_i,
   input  logic                   i0_exc_wb_i,     // exception at wb
   input  logic                   i1_exc_wb_i,
   input  logic                   int_valid_wb_i,  // interrupt taken
   input  xlen_t                  i0_inst_wb_i,
   input  xlen_t                  i1_inst_wb_i,
   input  pc_t                    i0_pc_wb_i,
   input  pc_t                    i1_pc_wb_i,
   input  logic [`DEC_CAUSE_W-1:0] cause_wb_i,
   input  xlen_t                  mtval_wb_i,
   output trace_insn_t            trace_insn_o,
   output trace_addr_t            trace_addr_o,
   output trace_lane_t            trace_valid_o,
   output trace_lane_t            trace_exc_o,
   output trace_lane_t            trace_int_o,
   output logic [`DEC_CAUSE_W-1:0] trace_ecause_o,
   output xlen_t                  trace_tval_o
);

   logic                    i0_valid_q, i1_valid_q;
   logic                    i0_exc_q, i1_exc_q;
   logic                    int_q;
   xlen_t                   i0_inst_q, i1_inst_q;
   pc_t                     i0_pc_q, i1_pc_q;
   logic [`DEC_CAUSE_W-1:0] cause_q;
   xlen_t                   tval_q;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         {i0_valid_q, i1_valid_q, i0_exc_q, i1_exc_q, int_q} <= '0;
      end else begin
         i0_valid_q <= i0_valid_wb_i;
         i1_valid_q <= i1_valid_wb_i;
         i0_exc_q   <= i0_exc_wb_i;
         i1_exc_q   <= i1_exc_wb_i;
         int_q      <= int_valid_wb_i;
      end
   end

   always_ff @(posedge clk) begin
      i0_inst_q <= i0_inst_wb_i;
      i1_inst_q <= i1_inst_wb_i;
      i0_pc_q   <= i0_pc_wb_i;
      i1_pc_q   <= i1_pc_wb_i;
      cause_q   <= cause_wb_i;
      tval_q    <= mtval_wb_i;
   end

   //**************************************************************************
   // WB1 lanes: 2 = interrupt, 1 = slot 1, 0 = slot 0
   //**************************************************************************
   assign trace_insn_o   = {{`DEC_XLEN{1'b0}}, i1_inst_q, i0_inst_q};
   assign trace_addr_o   = {{`DEC_XLEN{1'b0}}, i1_pc_q, 1'b0, i0_pc_q, 1'b0};  // byte addrs
   assign trace_valid_o  = {int_q, i1_valid_q | i1_exc_q, i0_valid_q | i0_exc_q};
   assign trace_exc_o    = {int_q, i1_exc_q, i0_exc_q};
   assign trace_int_o    = {int_q, 2'b00};
   assign trace_ecause_o = cause_q;  // shared by all lanes
   assign trace_tval_o   = tval_q;

endmodule

/* hdl/dec_operand_path.sv */
// decode operand path top
// value predictor lookup and table, register file, trace builder

`timescale 1ns/1ps
`include "dec_consts.svh"

module dec_operand_path
   import dec_pkg::*;
   import vp_pkg::*;
(
   input  logic                    clk,
   input  logic                    arst_n_i,
   input  pc_t                     fw_pc0_aln_i,    // align pcs
   input  pc_t                     fw_pc1_aln_i,
   input  logic                    fb_valid0_i,     // predictor feedback
   input  logic                    fb_valid1_i,
   input  logic                    fb_misp0_i,
   input  logic                    fb_misp1_i,
   input  pc_t                     fb_pc0_i,
   input  pc_t                     fb_pc1_i,
   input  xlen_t                   fb_actual0_i,
   input  xlen_t                   fb_actual1_i,
   input  gpr_addr_t               gpr_rs0_i,       // i0 rs1, i0 rs2, i1 rs1, i1 rs2
   input  gpr_addr_t               gpr_rs1_i,
   input  gpr_addr_t               gpr_rs2_i,
   input  gpr_addr_t               gpr_rs3_i,
   input  logic                    gpr_wen0_i,      // slot 0, slot 1, nb load
   input  logic                    gpr_wen1_i,
   input  logic                    gpr_wen2_i,
   input  gpr_addr_t               gpr_waddr0_i,
   input  gpr_addr_t               gpr_waddr1_i,
   input  gpr_addr_t               gpr_waddr2_i,
   input  xlen_t                   gpr_wd0_i,
   input  xlen_t                   gpr_wd1_i,
   input  xlen_t                   gpr_wd2_i,
   input  logic                    i0_valid_wb_i,   // writeback trace info
   input  logic                    i1_valid_wb_i,
   input  logic                    i0_exc_wb_i,
   input  logic                    i1_exc_wb_i,
   input  logic                    int_valid_wb_i,
   input  xlen_t                   i0_inst_wb_i,
   input  xlen_t                   i1_inst_wb_i,
   input  pc_t                     i0_pc_wb_i,
   input  pc_t                     i1_pc_wb_i,
   input  logic [`DEC_CAUSE_W-1:0] cause_wb_i,
   input  xlen_t                   mtval_wb_i,
   output xlen_t                   gpr_rd0_o,
   output xlen_t                   gpr_rd1_o,
   output xlen_t                   gpr_rd2_o,
   output xlen_t                   gpr_rd3_o,
   output vp_conf_t                vp_conf0_d_o,
   output vp_conf_t                vp_conf1_d_o,
   output logic                    vp_use0_e1_o,
   output logic                    vp_use1_e1_o,
   output xlen_t                   vp_value0_e1_o,
   output xlen_t                   vp_value1_e1_o,
   output trace_insn_t             trace_insn_o,
   output trace_addr_t             trace_addr_o,
   output trace_lane_t             trace_valid_o,
   output trace_lane_t             trace_exc_o,
   output trace_lane_t             trace_int_o,
   output logic [`DEC_CAUSE_W-1:0] trace_ecause_o,
   output xlen_t                   trace_tval_o
);

   vp_idx_t  rd_idx0, rd_idx1;      // lookup -> table
   logic     rd_valid0, rd_valid1;  // table -> lookup
   vp_tag_t  rd_tag0, rd_tag1;
   vp_conf_t rd_conf0, rd_conf1;
   xlen_t    rd_value0, rd_value1;

   dec_vp_lookup u_vp_lookup (
      .clk, .arst_n_i,
      .pc0_aln_i   (fw_pc0_aln_i),   .pc1_aln_i   (fw_pc1_aln_i),
      .rd_valid0_i (rd_valid0),      .rd_valid1_i (rd_valid1),
      .rd_tag0_i   (rd_tag0),        .rd_tag1_i   (rd_tag1),
      .rd_conf0_i  (rd_conf0),       .rd_conf1_i  (rd_conf1),
      .rd_value0_i (rd_value0),      .rd_value1_i (rd_value1),
      .rd_idx0_o   (rd_idx0),        .rd_idx1_o   (rd_idx1),
      .conf0_d_o   (vp_conf0_d_o),   .conf1_d_o   (vp_conf1_d_o),
      .use0_e1_o   (vp_use0_e1_o),   .use1_e1_o   (vp_use1_e1_o),
      .value0_e1_o (vp_value0_e1_o), .value1_e1_o (vp_value1_e1_o)
   );

   dec_vp_table u_vp_table (
      .clk, .arst_n_i,
      .rd_idx0_i   (rd_idx0),       .rd_idx1_i    (rd_idx1),
      .fb_valid0_i, .fb_valid1_i, .fb_misp0_i, .fb_misp1_i,
      .fb_pc0_i, .fb_pc1_i, .fb_actual0_i, .fb_actual1_i,
      .rd_valid0_o (rd_valid0),     .rd_valid1_o  (rd_valid1),
      .rd_tag0_o   (rd_tag0),       .rd_tag1_o    (rd_tag1),
      .rd_conf0_o  (rd_conf0),      .rd_conf1_o   (rd_conf1),
      .rd_value0_o (rd_value0),     .rd_value1_o  (rd_value1)
   );

   dec_gpr_file u_gpr_file (
      .clk,
      .rs0_i    (gpr_rs0_i),    .rs1_i    (gpr_rs1_i),
      .rs2_i    (gpr_rs2_i),    .rs3_i    (gpr_rs3_i),
      .wen0_i   (gpr_wen0_i),   .wen1_i   (gpr_wen1_i),   .wen2_i   (gpr_wen2_i),
      .waddr0_i (gpr_waddr0_i), .waddr1_i (gpr_waddr1_i), .waddr2_i (gpr_waddr2_i),
      .wd0_i    (gpr_wd0_i),    .wd1_i    (gpr_wd1_i),    .wd2_i    (gpr_wd2_i),
      .rd0_o    (gpr_rd0_o),    .rd1_o    (gpr_rd1_o),
      .rd2_o    (gpr_rd2_o),    .rd3_o    (gpr_rd3_o)
   );

   dec_trace_pack u_trace_pack (
      .clk, .arst_n_i,
      .i0_valid_wb_i, .i1_valid_wb_i, .i0_exc_wb_i, .i1_exc_wb_i, .int_valid_wb_i,
      .i0_inst_wb_i, .i1_inst_wb_i, .i0_pc_wb_i, .i1_pc_wb_i,
      .cause_wb_i, .mtval_wb_i,
      .trace_insn_o, .trace_addr_o, .trace_valid_o, .trace_exc_o, .trace_int_o,
      .trace_ecause_o, .trace_tval_o
   );

endmodule

/* verification/dec_tb_clkgen.sv */
// clock and reset generator for the testbench
// 8 ns clock, reset held low for the first 5 rising edges

`timescale 1ns/1ps

module dec_tb_clkgen (
   output logic clk_o,
   output logic arst_n_o
);

   localparam int HALF_PERIOD  = 4;  // ns
   localparam int RESET_CYCLES = 5;

   initial begin
      clk_o = 1'b0;
      forever #HALF_PERIOD clk_o = ~clk_o;
   end

   initial begin
      arst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      #1 arst_n_o = 1'b1;  // release clear of an edge
   end

endmodule

/* verification/dec_operand_path_tb.sv */
// testbench for the decode operand path
// predictor, register file and trace reference models
// negedge compare process, directed and random stimulus, watchdog

`timescale 1ns/1ps
`include "dec_consts.svh"

module dec_operand_path_tb
   import dec_pkg::*;
();

   localparam int N_LOOK  = 8;    // lookups on an empty table
   localparam int N_TRAIN = 24;   // directed training sequence
   localparam int N_VP    = 400;
   localparam int N_GPR   = 332;  // 32 fill + random
   localparam int N_TRC   = 200;
   localparam int TOTAL_CYCLES = 5 + N_LOOK + N_TRAIN + N_VP + N_GPR + N_TRC + 20;
   localparam pc_t PC_A = {16'h0000, 8'h5a, 7'h23};
   localparam pc_t PC_B = {16'h0000, 8'h5b, 7'h23};  // same index as PC_A

   logic                    clk, arst_n;
   pc_t                     pc_aln [2], fb_pc [2], wb_pc [2];
   logic                    fb_valid [2], fb_misp [2];
   xlen_t                   fb_act [2], wb_inst [2], wb_tval;
   gpr_addr_t               rs [4], wa [3];
   logic                    wen [3];
   xlen_t                   wd [3], rd [4];
   logic                    wb_v [2], wb_e [2], wb_int;
   logic [`DEC_CAUSE_W-1:0] wb_cause, tr_ecause;
   logic [`VP_CONF_W-1:0]   conf_d [2];
   logic                    use_e1 [2];
   xlen_t                   val_e1 [2], tr_tval;
   trace_insn_t             tr_insn;
   trace_addr_t             tr_addr;
   trace_lane_t             tr_valid, tr_exc, tr_int;

   // reference state, updated at each negedge for the coming edge
   logic                    m_valid [`VP_ENTRIES];
   logic [7:0]              m_tag [`VP_ENTRIES];
   logic [1:0]              m_conf [`VP_ENTRIES];
   xlen_t                   m_value [`VP_ENTRIES];
   logic [1:0]              e_conf_d [2];
   logic                    e_use_d [2], e_use_e1 [2];
   xlen_t                   e_val_d [2], e_val_e1 [2];
   xlen_t                   m_regs [32];
   logic                    m_known [32];       // written since start
   logic                    t_known, t_v [2], t_e [2], t_int;
   xlen_t                   t_inst [2], t_tval;
   pc_t                     t_pc [2];
   logic [`DEC_CAUSE_W-1:0] t_cause;
   int                      n_checks, n_errors;

   dec_tb_clkgen u_clkgen (.clk_o (clk), .arst_n_o (arst_n));

   dec_operand_path u_dec_operand_path (
      .clk            (clk),         .arst_n_i       (arst_n),
      .fw_pc0_aln_i   (pc_aln[0]),   .fw_pc1_aln_i   (pc_aln[1]),
      .fb_valid0_i    (fb_valid[0]), .fb_valid1_i    (fb_valid[1]),
      .fb_misp0_i     (fb_misp[0]),  .fb_misp1_i     (fb_misp[1]),
      .fb_pc0_i       (fb_pc[0]),    .fb_pc1_i       (fb_pc[1]),
      .fb_actual0_i   (fb_act[0]),   .fb_actual1_i   (fb_act[1]),
      .gpr_rs0_i      (rs[0]),       .gpr_rs1_i      (rs[1]),
      .gpr_rs2_i      (rs[2]),       .gpr_rs3_i      (rs[3]),
      .gpr_wen0_i     (wen[0]),      .gpr_wen1_i     (wen[1]),      .gpr_wen2_i   (wen[2]),
      .gpr_waddr0_i   (wa[0]),       .gpr_waddr1_i   (wa[1]),       .gpr_waddr2_i (wa[2]),
      .gpr_wd0_i      (wd[0]),       .gpr_wd1_i      (wd[1]),       .gpr_wd2_i    (wd[2]),
      .i0_valid_wb_i  (wb_v[0]),     .i1_valid_wb_i  (wb_v[1]),
      .i0_exc_wb_i    (wb_e[0]),     .i1_exc_wb_i    (wb_e[1]),
      .int_valid_wb_i (wb_int),
      .i0_inst_wb_i   (wb_inst[0]),  .i1_inst_wb_i   (wb_inst[1]),
      .i0_pc_wb_i     (wb_pc[0]),    .i1_pc_wb_i     (wb_pc[1]),
      .cause_wb_i     (wb_cause),    .mtval_wb_i     (wb_tval),
      .gpr_rd0_o      (rd[0]),       .gpr_rd1_o      (rd[1]),
      .gpr_rd2_o      (rd[2]),       .gpr_rd3_o      (rd[3]),
      .vp_conf0_d_o   (conf_d[0]),   .vp_conf1_d_o   (conf_d[1]),
      .vp_use0_e1_o   (use_e1[0]),   .vp_use1_e1_o   (use_e1[1]),
      .vp_value0_e1_o (val_e1[0]),   .vp_value1_e1_o (val_e1[1]),
      .trace_insn_o   (tr_insn),     .trace_addr_o   (tr_addr),
      .trace_valid_o  (tr_valid),    .trace_exc_o    (tr_exc),      .trace_int_o  (tr_int),
      .trace_ecause_o (tr_ecause),   .trace_tval_o   (tr_tval)
   );

   //**************************************************************************
   // reference functions
   //**************************************************************************
   function automatic logic [6:0] pc_index(input pc_t pc);
      return pc[6:0];  // byte pc bits 7:1
   endfunction

   function automatic logic [7:0] pc_tag(input pc_t pc);
      return pc[14:7];  // byte pc bits 15:8
   endfunction

   // 0 none, 1 train, 2 replace
   function automatic int fb_action(input logic v, input logic misp, input pc_t pc);
      if (!v) return 0;
      if (misp || !m_valid[pc_index(pc)] || (m_tag[pc_index(pc)] != pc_tag(pc))) return 2;
      return 1;
   endfunction

   function automatic trace_insn_t insn_ref(input xlen_t i0, input xlen_t i1);
      return {32'h0, i1, i0};  // slot 0 lowest
   endfunction

   function automatic trace_addr_t addr_ref(input pc_t pc0, input pc_t pc1);
      return {32'h0, pc1, 1'b0, pc0, 1'b0};
   endfunction

   task automatic check_val(input string name, input logic [95:0] exp, input logic [95:0] got);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("[FAIL] %s exp %h got %h at %0t", name, exp, got, $time);
      end
   endtask

   task automatic reset_model();
      for (int i = 0; i < `VP_ENTRIES; i++) m_valid[i] = 1'b0;
      for (int s = 0; s < 2; s++) begin
         e_conf_d[s] = 2'd0;
         e_use_d[s]  = 1'b0;
         e_use_e1[s] = 1'b0;
         t_v[s]      = 1'b0;
         t_e[s]      = 1'b0;
      end
      t_int   = 1'b0;
      t_known = 1'b0;  // trace data flops have no reset
   endtask

   task automatic compare_outputs();
      xlen_t exp_rd;
      for (int s = 0; s < 2; s++) begin
         check_val($sformatf("vp_conf%0d_d", s), 96'(e_conf_d[s]), 96'(conf_d[s]));
         check_val($sformatf("vp_use%0d_e1", s), 96'(e_use_e1[s]), 96'(use_e1[s]));
         if (e_use_e1[s]) begin
            check_val($sformatf("vp_value%0d_e1", s), 96'(e_val_e1[s]), 96'(val_e1[s]));
         end
      end
      for (int p = 0; p < 4; p++) begin
         exp_rd = (rs[p] == 5'd0) ? 32'h0 : m_regs[rs[p]];
         if ((rs[p] == 5'd0) || m_known[rs[p]])
            check_val($sformatf("gpr_rd%0d", p), 96'(exp_rd), 96'(rd[p]));
      end
      check_val("trace_valid", 96'({t_int, t_v[1] | t_e[1], t_v[0] | t_e[0]}), 96'(tr_valid));
      check_val("trace_exc", 96'({t_int, t_e[1], t_e[0]}), 96'(tr_exc));
      check_val("trace_int", 96'({t_int, 2'b00}), 96'(tr_int));
      if (t_known) begin
         check_val("trace_insn", insn_ref(t_inst[0], t_inst[1]), tr_insn);
         check_val("trace_addr", addr_ref(t_pc[0], t_pc[1]), tr_addr);
         check_val("trace_ecause", 96'(t_cause), 96'(tr_ecause));
         check_val("trace_tval", 96'(t_tval), 96'(tr_tval));
      end
   endtask

   task automatic advance_model();
      int         act [2];
      int         p;
      logic [6:0] ix;
      logic       hit;
      for (int s = 0; s < 2; s++) begin
         e_use_e1[s] = e_use_d[s];
         e_val_e1[s] = e_val_d[s];
         ix          = pc_index(pc_aln[s]);
         hit         = m_valid[ix] && (m_tag[ix] == pc_tag(pc_aln[s]));  // old contents
         e_conf_d[s] = hit ? m_conf[ix] : 2'd0;
         e_use_d[s]  = hit && (m_conf[ix] == 2'd3);
         e_val_d[s]  = m_value[ix];
         act[s]      = fb_action(fb_valid[s], fb_misp[s], fb_pc[s]);
      end
      if ((act[1] != 0) && (pc_index(fb_pc[1]) == pc_index(fb_pc[0]))) act[0] = 0;  // slot 1 wins
      for (int s = 0; s < 2; s++) begin
         ix = pc_index(fb_pc[s]);
         if (act[s] == 2) begin
            m_valid[ix] = 1'b1;
            m_tag[ix]   = pc_tag(fb_pc[s]);
            m_value[ix] = fb_act[s];
            m_conf[ix]  = 2'd0;
         end else if ((act[s] == 1) && (m_conf[ix] != 2'd3)) begin
            m_conf[ix] = m_conf[ix] + 2'd1;  // saturates at 3
         end
      end
      for (int k = 0; k < 3; k++) begin
         p = (k == 0) ? 2 : k - 1;  // load, slot 0, slot 1
         if (wen[p] && (wa[p] != 5'd0)) begin
            m_regs[wa[p]]  = wd[p];
            m_known[wa[p]] = 1'b1;
         end
      end
      t_known = 1'b1;
      t_v     = wb_v;
      t_e     = wb_e;
      t_int   = wb_int;
      t_inst  = wb_inst;
      t_pc    = wb_pc;
      t_cause = wb_cause;
      t_tval  = wb_tval;
   endtask

   always @(negedge clk) begin
      if (!arst_n) begin
         reset_model();
      end else begin
         compare_outputs();
         advance_model();
      end
   end

   //**************************************************************************
   // stimulus
   //**************************************************************************
   task automatic next_cycle();
      @(posedge clk);
      #1;  // drive clear of the edge
   endtask

   task automatic idle_inputs();
      for (int s = 0; s < 2; s++) begin
         pc_aln[s]   = '0;
         fb_valid[s] = 1'b0;
         fb_misp[s]  = 1'b0;
         fb_pc[s]    = '0;
         fb_act[s]   = '0;
         wb_v[s]     = 1'b0;
         wb_e[s]     = 1'b0;
         wb_inst[s]  = '0;
         wb_pc[s]    = '0;
      end
      for (int p = 0; p < 4; p++) rs[p] = '0;
      for (int p = 0; p < 3; p++) begin
         wen[p] = 1'b0;
         wa[p]  = '0;
         wd[p]  = '0;
      end
      wb_int   = 1'b0;
      wb_cause = '0;
      wb_tval  = '0;
   endtask

   task automatic feed(input int s, input pc_t pc, input xlen_t val, input logic misp);
      fb_valid[s] = 1'b1;
      fb_pc[s]    = pc;
      fb_act[s]   = val;
      fb_misp[s]  = misp;
   endtask

   // few indices, one common tag, so entries train and alias
   function automatic pc_t rand_pc();
      logic [15:0] hi;
      logic [7:0]  tag;
      logic [6:0]  idx;
      hi  = 16'($urandom());
      tag = ($urandom_range(0, 7) == 0) ? 8'h02 : 8'h01;
      idx = 7'($urandom_range(0, 5));
      return {hi, tag, idx};
   endfunction

   initial begin
      void'($urandom(32'h89ba));
      n_checks   = 0;
      n_errors   = 0;
      for (int r = 0; r < 32; r++) m_known[r] = 1'b0;
      idle_inputs();
      @(posedge arst_n);

      // lookups on the empty table
      repeat (N_LOOK) begin
         next_cycle();
         pc_aln[0] = 31'($urandom());
         pc_aln[1] = 31'($urandom());
      end

      // training, mispredict, aliasing tag, shared index on both slots
      next_cycle();
      pc_aln[0] = PC_A;
      pc_aln[1] = PC_B;
      feed(0, PC_A, 32'hcafe_0001, 1'b0);
      repeat (7) next_cycle();
      fb_valid[0] = 1'b0;
      repeat (4) next_cycle();
      feed(0, PC_A, 32'hbeef_0002, 1'b1);
      next_cycle();
      fb_valid[0] = 1'b0;
      repeat (3) next_cycle();
      feed(0, PC_B, 32'h0bad_0003, 1'b0);
      next_cycle();
      fb_valid[0] = 1'b0;
      repeat (3) next_cycle();
      feed(0, PC_B, 32'h1111_0004, 1'b1);
      feed(1, PC_B, 32'h2222_0005, 1'b1);
      next_cycle();
      idle_inputs();
      repeat (3) next_cycle();

      // pipelined lookups with random feedback
      repeat (N_VP) begin
         next_cycle();
         for (int s = 0; s < 2; s++) begin
            pc_aln[s]   = rand_pc();
            fb_valid[s] = ($urandom_range(0, 3) != 0);
            fb_misp[s]  = ($urandom_range(0, 9) == 0);
            fb_pc[s]    = rand_pc();
            fb_act[s]   = $urandom();
         end
      end
      next_cycle();
      idle_inputs();

      // fill x0..x31, then random traffic on a few registers
      for (int r = 0; r < 32; r++) begin
         next_cycle();
         wen[0] = 1'b1;
         wa[0]  = 5'(r);
         wd[0]  = $urandom();
      end
      repeat (N_GPR - 32) begin
         next_cycle();
         for (int p = 0; p < 4; p++) rs[p] = (p < 2) ? 5'($urandom_range(0, 7)) : 5'($urandom());
         for (int p = 0; p < 3; p++) begin
            wen[p] = 1'($urandom_range(0, 1));
            wa[p]  = 5'($urandom_range(0, 7));  // collisions and x0
            wd[p]  = $urandom();
         end
      end
      next_cycle();
      idle_inputs();

      // writeback retirement, exceptions, interrupts
      repeat (N_TRC) begin
         next_cycle();
         for (int s = 0; s < 2; s++) begin
            wb_v[s]    = 1'($urandom_range(0, 1));
            wb_e[s]    = ($urandom_range(0, 5) == 0);
            wb_inst[s] = $urandom();
            wb_pc[s]   = 31'($urandom());
         end
         wb_int   = ($urandom_range(0, 7) == 0);
         wb_cause = 5'($urandom());
         wb_tval  = $urandom();
      end
      next_cycle();
      idle_inputs();
      repeat (4) next_cycle();

      $display("checks %0d errors %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

   // watchdog
   initial begin
      #((TOTAL_CYCLES + 200) * 8);
      $display("timeout after %0d cycles, checks %0d errors %0d",
               TOTAL_CYCLES + 200, n_checks, n_errors);
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule

/* dec_operand_path.f */
+incdir+hdl
hdl/dec_pkg.sv
hdl/vp_pkg.sv
hdl/dec_vp_lookup.sv
hdl/dec_vp_table.sv
hdl/dec_gpr_file.sv
hdl/dec_trace_pack.sv
hdl/dec_operand_path.sv
verification/dec_tb_clkgen.sv
verification/dec_operand_path_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log for the result
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module dec_operand_path_tb \
   -f dec_operand_path.f -o dec_operand_path_sim \
   && ./obj_dir/dec_operand_path_sim > sim.log 2>&1 \
   || echo "build or simulation returned an error"

[ -f sim.log ] && cat sim.log
grep -q "SIMULATION PASSED" sim.log 2>/dev/null && echo "result: pass" && exit 0 \
   || echo "result: fail"
exit 1
